//--- cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// first instruction fetch after reset
`define CPU_RESET_PC 32'h0000_0100
`define CPU_NREGS    16

// ------------------------------------------------------------
// opcodes, instruction bits 7..0
// ------------------------------------------------------------
`define OP_NOP  8'hEA
`define OP_ADD  8'h01	// Rt = Ra + R[imm16[3:0]]
`define OP_SUB  8'h02
`define OP_AND  8'h03
`define OP_OR   8'h04
`define OP_EOR  8'h05
`define OP_ADDI 8'h06	// Rt = Ra + sext(imm16)
`define OP_LD   8'h07	// Rt = mem[Ra + sext(imm16)]
`define OP_ST   8'h08	// mem[Ra + sext(imm16)] = Rt
`define OP_BCC  8'h09	// condition in the Rt field

// ------------------------------------------------------------
// branch conditions, 4'hF is never taken
// ------------------------------------------------------------
`define CC_EQ 4'h0
`define CC_NE 4'h1
`define CC_PL 4'h2
`define CC_MI 4'h3
`define CC_CS 4'h4
`define CC_CC 4'h5
`define CC_VS 4'h6
`define CC_VC 4'h7
`define CC_RA 4'h8
`define CC_HI 4'h9
`define CC_LS 4'hA
`define CC_GE 4'hB
`define CC_LT 4'hC
`define CC_GT 4'hD
`define CC_LE 4'hE

`endif

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;	// data word
	typedef logic [31:0] addr_t;	// byte address
	typedef logic [3:0]  reg_idx_t;
	typedef logic [7:0]  opcode_t;
	typedef logic [3:0]  cond_t;

	// bit 3 n, bit 2 z, bit 1 c, bit 0 v
	typedef logic [3:0]  flags_t;

	// control sequencer, one instruction at a time
	typedef enum logic [2:0] {
		RESET,
		FETCH,
		DECODE,
		EXEC,
		MEM,
		WRITEBACK
	} ctl_state_t;

endpackage

`default_nettype wire

//--- cpu_regfile.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_regfile (
	input  wire                clk,
	input  wire                rst_i,
	input  wire cpu_pkg::reg_idx_t ra_idx_i,
	input  wire cpu_pkg::reg_idx_t rb_idx_i,
	output cpu_pkg::word_t     rdata_a_o,
	output cpu_pkg::word_t     rdata_b_o,
	input  wire                wr_en_i,
	input  wire cpu_pkg::reg_idx_t wr_idx_i,
	input  wire cpu_pkg::word_t    wr_data_i
);

	cpu_pkg::word_t regs [`CPU_NREGS];

	// ------------------------------------------------------------
	// write port, r0 is never written
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (wr_en_i && (wr_idx_i != '0)) begin
			regs[wr_idx_i] <= wr_data_i;
		end
	end

	// asynchronous read ports
	assign rdata_a_o = (ra_idx_i == '0) ? '0 : regs[ra_idx_i];
	assign rdata_b_o = (rb_idx_i == '0) ? '0 : regs[rb_idx_i];	// r0 reads as zero

endmodule

`default_nettype wire

//--- cpu_alu.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_alu (
	input  wire cpu_pkg::opcode_t op_i,
	input  wire cpu_pkg::word_t   a_i,
	input  wire cpu_pkg::word_t   b_i,
	input  wire [15:0]            imm_i,
	input  wire cpu_pkg::flags_t  flags_i,
	output cpu_pkg::word_t        result_o,
	output cpu_pkg::flags_t       flags_o
);

	cpu_pkg::word_t imm_ext;
	cpu_pkg::word_t opb;
	logic           use_imm;
	logic [32:0]    sum;
	logic [32:0]    diff;
	logic           v_add;
	logic           v_sub;

	assign imm_ext = {{16{imm_i[15]}}, imm_i};
	assign use_imm = (op_i == `OP_ADDI) || (op_i == `OP_LD) || (op_i == `OP_ST);
	assign opb     = use_imm ? imm_ext : b_i;

	// 33 bit add and subtract, bit 32 is the carry out
	assign sum  = {1'b0, a_i} + {1'b0, opb};
	assign diff = {1'b0, a_i} - {1'b0, opb};

	// overflow when the sign of the result can't follow from the operands
	assign v_add = (a_i[31] == opb[31]) && (sum[31] != a_i[31]);
	assign v_sub = (a_i[31] != opb[31]) && (diff[31] != a_i[31]);

	always_comb begin
		case (op_i)
			`OP_SUB: result_o = diff[31:0];
			`OP_AND: result_o = a_i & opb;
			`OP_OR:  result_o = a_i | opb;
			`OP_EOR: result_o = a_i ^ opb;
			default: result_o = sum[31:0];	// add, addi and ld/st address
		endcase
	end

	// ------------------------------------------------------------
	// next flags
	// ------------------------------------------------------------
	always_comb begin
		flags_o = flags_i;
		case (op_i)
			`OP_ADD, `OP_ADDI: flags_o = {sum[31], ~|sum[31:0], sum[32], v_add};
			`OP_SUB:           flags_o = {diff[31], ~|diff[31:0], ~diff[32], v_sub};	// c = no borrow
			`OP_AND, `OP_OR, `OP_EOR:
				flags_o = {result_o[31], ~|result_o, flags_i[1:0]};	// c and v kept
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- cpu_branch_eval.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_branch_eval (
	input  wire cpu_pkg::cond_t  cond_i,
	input  wire cpu_pkg::flags_t flags_i,
	output logic                 taken_o
);

	logic n, z, c, v;

	assign {n, z, c, v} = flags_i;

	always_comb begin
		case (cond_i)
			`CC_EQ:  taken_o = z;
			`CC_NE:  taken_o = !z;
			`CC_PL:  taken_o = !n;
			`CC_MI:  taken_o = n;
			`CC_CS:  taken_o = c;
			`CC_CC:  taken_o = !c;
			`CC_VS:  taken_o = v;
			`CC_VC:  taken_o = !v;
			`CC_RA:  taken_o = 1'b1;
			`CC_HI:  taken_o = c && !z;	// unsigned higher
			`CC_LS:  taken_o = !c || z;
			`CC_GE:  taken_o = (n == v);	// signed compares
			`CC_LT:  taken_o = (n != v);
			`CC_GT:  taken_o = (n == v) && !z;
			`CC_LE:  taken_o = z || (n != v);
			default: taken_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- cpu_control.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_control (
	input  wire                    clk,
	input  wire                    rst_i,
	input  wire cpu_pkg::word_t    dat_i,
	input  wire                    ack_i,
	output logic                   cyc_o,
	output logic                   stb_o,
	output logic                   we_o,
	output cpu_pkg::addr_t         adr_o,
	output cpu_pkg::word_t         dat_o,
	output cpu_pkg::reg_idx_t      ra_idx_o,
	output cpu_pkg::reg_idx_t      rb_idx_o,
	input  wire cpu_pkg::word_t    rdata_a_i,
	input  wire cpu_pkg::word_t    rdata_b_i,
	output logic                   wr_en_o,
	output cpu_pkg::reg_idx_t      wr_idx_o,
	output cpu_pkg::word_t         wr_data_o,
	output cpu_pkg::opcode_t       alu_op_o,
	output cpu_pkg::word_t         alu_a_o,
	output cpu_pkg::word_t         alu_b_o,
	output logic [15:0]            alu_imm_o,
	output cpu_pkg::flags_t        flags_o,
	input  wire cpu_pkg::word_t    alu_result_i,
	input  wire cpu_pkg::flags_t   alu_flags_i,
	output cpu_pkg::cond_t         cond_o,
	input  wire                    taken_i
);

	cpu_pkg::ctl_state_t state;
	cpu_pkg::addr_t      pc;
	cpu_pkg::addr_t      br_target;
	cpu_pkg::word_t      ir;
	cpu_pkg::word_t      opa;
	cpu_pkg::word_t      opb;
	cpu_pkg::word_t      ld_data;
	cpu_pkg::flags_t     flags;
	cpu_pkg::opcode_t    op;
	logic                is_alu;
	logic                is_mem;
	logic                fetch_start;
	logic                fetch_done;
	logic                mem_start;
	logic                mem_done;

	// ------------------------------------------------------------
	// instruction fields and decode
	// ------------------------------------------------------------
	assign op     = ir[7:0];
	assign is_alu = (op == `OP_ADD) || (op == `OP_SUB) || (op == `OP_AND) ||
	                (op == `OP_OR) || (op == `OP_EOR) || (op == `OP_ADDI);
	assign is_mem = (op == `OP_LD) || (op == `OP_ST);

	assign ra_idx_o = ir[15:12];
	assign rb_idx_o = (op == `OP_ST) ? ir[11:8] : ir[19:16];	// store data comes from Rt

	assign alu_op_o  = op;
	assign alu_a_o   = opa;
	assign alu_b_o   = opb;
	assign alu_imm_o = ir[31:16];
	assign flags_o   = flags;
	assign cond_o    = ir[11:8];

	// pc already points past the branch here
	assign br_target = pc + {{14{ir[31]}}, ir[31:16], 2'b00};

	// register writeback, alu result in EXEC or load data in WRITEBACK
	assign wr_en_o   = ((state == cpu_pkg::EXEC) && is_alu) || (state == cpu_pkg::WRITEBACK);
	assign wr_idx_o  = ir[11:8];
	assign wr_data_o = (state == cpu_pkg::WRITEBACK) ? ld_data : alu_result_i;

	// bus events
	assign fetch_start = (state == cpu_pkg::FETCH) && !stb_o;
	assign fetch_done  = (state == cpu_pkg::FETCH) && stb_o && ack_i;
	assign mem_start   = (state == cpu_pkg::EXEC) && is_mem;
	assign mem_done    = (state == cpu_pkg::MEM) && ack_i;

	// ------------------------------------------------------------
	// sequencer and bus handshake
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= cpu_pkg::RESET;
			pc    <= `CPU_RESET_PC;
			flags <= '0;
			cyc_o <= 1'b0;
			stb_o <= 1'b0;
			we_o  <= 1'b0;
		end else begin
			case (state)
				cpu_pkg::RESET: state <= cpu_pkg::FETCH;
				cpu_pkg::FETCH: begin
					if (fetch_start) begin
						cyc_o <= 1'b1;
						stb_o <= 1'b1;
						we_o  <= 1'b0;
					end else if (fetch_done) begin
						cyc_o <= 1'b0;	// drop on the ack edge
						stb_o <= 1'b0;
						pc    <= pc + 32'd4;
						state <= cpu_pkg::DECODE;
					end
				end
				cpu_pkg::DECODE: state <= cpu_pkg::EXEC;
				cpu_pkg::EXEC: begin
					state <= cpu_pkg::FETCH;
					if (is_alu)
						flags <= alu_flags_i;
					if ((op == `OP_BCC) && taken_i)
						pc <= br_target;
					if (mem_start) begin
						cyc_o <= 1'b1;
						stb_o <= 1'b1;
						we_o  <= (op == `OP_ST);
						state <= cpu_pkg::MEM;
					end
				end
				cpu_pkg::MEM: begin
					if (mem_done) begin
						cyc_o <= 1'b0;
						stb_o <= 1'b0;
						we_o  <= 1'b0;
						state <= we_o ? cpu_pkg::FETCH : cpu_pkg::WRITEBACK;
					end
				end
				cpu_pkg::WRITEBACK: state <= cpu_pkg::FETCH;
				default: state <= cpu_pkg::RESET;
			endcase
		end
	end

	// ------------------------------------------------------------
	// datapath registers
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (fetch_start)
			adr_o <= {pc[31:2], 2'b00};
		else if (mem_start)
			adr_o <= {alu_result_i[31:2], 2'b00};	// word aligned
		if (mem_start)
			dat_o <= opb;
		if (fetch_done)
			ir <= dat_i;
		if (state == cpu_pkg::DECODE) begin
			opa <= rdata_a_i;
			opb <= rdata_b_i;
		end
		if (mem_done)
			ld_data <= dat_i;	// only used after a load
	end

endmodule

`default_nettype wire

//--- cpu_top.sv
`default_nettype none
`timescale 1ns/1ns

module cpu_top (
	input  wire                 clk,
	input  wire                 rst_i,
	input  wire cpu_pkg::word_t dat_i,
	input  wire                 ack_i,
	output wire                 cyc_o,
	output wire                 stb_o,
	output wire                 we_o,
	output cpu_pkg::addr_t      adr_o,
	output cpu_pkg::word_t      dat_o
);

	wire cpu_pkg::reg_idx_t ra_idx;
	wire cpu_pkg::reg_idx_t rb_idx;
	wire cpu_pkg::reg_idx_t wr_idx;
	wire cpu_pkg::word_t    rdata_a;
	wire cpu_pkg::word_t    rdata_b;
	wire cpu_pkg::word_t    wr_data;
	wire                    wr_en;
	wire cpu_pkg::opcode_t  alu_op;
	wire cpu_pkg::word_t    alu_a;
	wire cpu_pkg::word_t    alu_b;
	wire [15:0]             alu_imm;
	wire cpu_pkg::word_t    alu_result;
	wire cpu_pkg::flags_t   flags;
	wire cpu_pkg::flags_t   next_flags;
	wire cpu_pkg::cond_t    cond;
	wire                    taken;

	cpu_control u_control (
		.clk(clk), .rst_i(rst_i), .dat_i(dat_i), .ack_i(ack_i),
		.cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o), .adr_o(adr_o), .dat_o(dat_o),
		.ra_idx_o(ra_idx), .rb_idx_o(rb_idx), .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
		.wr_en_o(wr_en), .wr_idx_o(wr_idx), .wr_data_o(wr_data),
		.alu_op_o(alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_imm_o(alu_imm),
		.flags_o(flags), .alu_result_i(alu_result), .alu_flags_i(next_flags),
		.cond_o(cond), .taken_i(taken)
	);

	cpu_regfile u_regfile (
		.clk(clk), .rst_i(rst_i), .ra_idx_i(ra_idx), .rb_idx_i(rb_idx),
		.rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
		.wr_en_i(wr_en), .wr_idx_i(wr_idx), .wr_data_i(wr_data)
	);

	cpu_alu u_alu (
		.op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .imm_i(alu_imm), .flags_i(flags),
		.result_o(alu_result), .flags_o(next_flags)
	);

	cpu_branch_eval u_branch (.cond_i(cond), .flags_i(flags), .taken_o(taken));

endmodule

`default_nettype wire

//--- tb_cpu_properties.sv
`default_nettype none
`timescale 1ns/1ns

module tb_cpu_properties (
	input wire                 clk,
	input wire                 rst_i,
	input wire                 cyc_o,
	input wire                 stb_o,
	input wire                 we_o,
	input wire                 ack_i,
	input wire cpu_pkg::addr_t adr_o,
	input wire cpu_pkg::word_t dat_o
);

	int violations = 0;	// failed assertions so far

	// a strobe only ever inside a bus cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i) stb_o |-> cyc_o)
		else begin
			$error("stb_o high without cyc_o");
			violations++;
		end

	// no ack yet, so the request stays exactly as it was
	req_held: assert property (@(posedge clk) disable iff (rst_i)
		(stb_o && !ack_i) |=> (stb_o && $stable(adr_o) && $stable(we_o) && $stable(dat_o)))
		else begin
			$error("bus request changed before ack_i");
			violations++;
		end

	we_in_cyc: assert property (@(posedge clk) disable iff (rst_i) we_o |-> cyc_o)
		else begin
			$error("we_o high without cyc_o");
			violations++;
		end

endmodule

bind cpu_control tb_cpu_properties u_bus_props (
	.clk(clk), .rst_i(rst_i), .cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o),
	.ack_i(ack_i), .adr_o(adr_o), .dat_o(dat_o)
);

`default_nettype wire

//--- tb_cpu.sv
`default_nettype none
`timescale 1ns/1ns
`include "cpu_consts.svh"

module tb_cpu;

	localparam logic [31:0] MARK_ADDR = 32'h0000_03FC;	// last word of memory marks the end

	logic                clk = 1'b0;
	logic                rst_i;
	logic                ack_i = 1'b0;
	cpu_pkg::word_t      dat_i = '0;
	wire                 cyc_o;
	wire                 stb_o;
	wire                 we_o;
	wire cpu_pkg::addr_t adr_o;
	wire cpu_pkg::word_t dat_o;

	cpu_pkg::word_t      mem [256];
	cpu_pkg::word_t      prog [$];
	cpu_pkg::addr_t      pre_addr [$];	// preset data words
	cpu_pkg::word_t      pre_data [$];
	cpu_pkg::addr_t      exp_addr [$];
	cpu_pkg::word_t      exp_data [$];
	cpu_pkg::addr_t      st_addr [$];
	cpu_pkg::word_t      st_data [$];
	cpu_pkg::addr_t      rd_addr [$];
	logic [63:0]         all_st [$];	// address and data of every store in a pass
	logic [63:0]         ref_st [$];
	int                  delay_left = 0;
	bit                  rand_ack;
	int                  errors;
	int                  checks;

	cpu_top UUT (
		.clk(clk), .rst_i(rst_i), .dat_i(dat_i), .ack_i(ack_i), .cyc_o(cyc_o),
		.stb_o(stb_o), .we_o(we_o), .adr_o(adr_o), .dat_o(dat_o)
	);

	always #50 clk = ~clk;

	// ------------------------------------------------------------
	// bus memory answering on the falling edge
	// ------------------------------------------------------------
	initial begin
		void'($urandom(32'hd0d1_dd38));	// seed for the ack delays
		forever begin
			@(negedge clk);
			if (!stb_o || ack_i) begin
				ack_i = 1'b0;
				delay_left = rand_ack ? int'($urandom % 4) : 0;
			end else if (delay_left > 0) begin
				delay_left = delay_left - 1;	// late ack
			end else begin
				ack_i = 1'b1;
				if (we_o) begin
					mem[adr_o[9:2]] = dat_o;
					st_addr.push_back(adr_o);
					st_data.push_back(dat_o);
					all_st.push_back({adr_o, dat_o});
				end else begin
					dat_i = mem[adr_o[9:2]];
					rd_addr.push_back(adr_o);
				end
			end
		end
	end

	function automatic cpu_pkg::word_t encode(input logic [7:0] op, input logic [3:0] rt,
		input logic [3:0] ra, input logic [15:0] imm);
		return {imm, ra, rt, op};
	endfunction

	function automatic cpu_pkg::word_t fill_word(input int idx);
		return 32'hA5C3_0000 ^ 32'(idx * 4);	// follows the byte address
	endfunction

	// branch decision from the flags a compare of a and b leaves behind
	function automatic logic cond_model(input logic [3:0] cc, input logic [31:0] a,
		input logic [31:0] b);
		logic [31:0] d;
		logic        n;
		logic        z;
		logic        c;
		logic        v;
		d = a - b;
		n = d[31];
		z = (d == 32'h0);
		c = (a >= b);	// no borrow
		v = (a[31] != b[31]) && (d[31] != a[31]);
		case (cc)
			`CC_EQ: return z;
			`CC_NE: return !z;
			`CC_PL: return !n;
			`CC_MI: return n;
			`CC_CS: return c;
			`CC_CC: return !c;
			`CC_VS: return v;
			`CC_VC: return !v;
			`CC_RA: return 1'b1;
			`CC_HI: return c && !z;
			`CC_LS: return !c || z;
			`CC_GE: return n == v;
			`CC_LT: return n != v;
			`CC_GT: return (n == v) && !z;
			`CC_LE: return z || (n != v);
			default: return 1'b0;
		endcase
	endfunction

	task automatic clear_program();
		prog.delete();
		pre_addr.delete();
		pre_data.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	// marker store of r0, then a branch to itself
	task automatic end_program();
		prog.push_back(encode(`OP_ST, 4'd0, 4'd0, MARK_ADDR[15:0]));
		prog.push_back(encode(`OP_BCC, `CC_RA, 4'd0, 16'hFFFF));
		exp_addr.push_back(MARK_ADDR);
		exp_data.push_back(32'h0);
	endtask

	// ------------------------------------------------------------
	// reset, load, run to the marker store, compare stores
	// ------------------------------------------------------------
	task automatic run_program();
		int cycles;
		@(negedge clk);
		rst_i = 1'b1;
		@(posedge clk);
		for (int i = 0; i < 256; i++)
			mem[8'(i)] = fill_word(i);
		for (int i = 0; i < prog.size(); i++)
			mem[8'((`CPU_RESET_PC >> 2) + i)] = prog[i];
		for (int i = 0; i < pre_addr.size(); i++)
			mem[pre_addr[i][9:2]] = pre_data[i];
		st_addr.delete();
		st_data.delete();
		rd_addr.delete();
		repeat (15) @(posedge clk);
		@(negedge clk);
		checks++;
		if ({cyc_o, stb_o, we_o} != 3'b000) begin
			errors++;
			$display("ERR {cyc_o,stb_o,we_o} exp %h got %h", 3'h0, {cyc_o, stb_o, we_o});
		end
		rst_i = 1'b0;
		cycles = 0;
		while (!(st_addr.size() > 0 && st_addr[$] == MARK_ADDR) && cycles < 3000) begin
			@(posedge clk);
			cycles++;
		end
		checks++;
		if (cycles >= 3000) begin
			errors++;
			$display("timeout: the program never stored to the marker address");
		end else if (st_addr.size() != exp_addr.size()) begin
			errors++;
			$display("wrong number of stores: expected %0d, got %0d",
				exp_addr.size(), st_addr.size());
		end else begin
			for (int i = 0; i < exp_addr.size(); i++) begin
				if (st_addr[i] != exp_addr[i]) begin
					errors++;
					$display("ERR adr_o store %0d exp %h got %h", i, exp_addr[i], st_addr[i]);
				end
				if (st_data[i] != exp_data[i]) begin
					errors++;
					$display("ERR dat_o store %0d exp %h got %h", i, exp_data[i], st_data[i]);
				end
			end
		end
	endtask

	task automatic fetch_test();
		clear_program();
		repeat (3) prog.push_back(encode(`OP_NOP, 4'd0, 4'd0, 16'h0));
		end_program();
		run_program();
		for (int i = 0; i < 4; i++) begin
			checks++;
			if (rd_addr.size() <= i || rd_addr[i] != `CPU_RESET_PC + 4 * i) begin
				errors++;
				$display("ERR adr_o fetch %0d exp %h got %h", i, `CPU_RESET_PC + 4 * i,
					rd_addr[i]);
			end
		end
	endtask

	task automatic alu_test();
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		a = 32'h0000_1234;
		b = 32'hFFFF_8765;	// imm16 sign extended
		clear_program();
		prog.push_back(encode(`OP_ADDI, 4'd1, 4'd0, 16'h1234));
		prog.push_back(encode(`OP_ADDI, 4'd2, 4'd0, 16'h8765));
		prog.push_back(encode(`OP_ADD, 4'd3, 4'd1, 16'd2));
		prog.push_back(encode(`OP_SUB, 4'd4, 4'd1, 16'd2));
		prog.push_back(encode(`OP_AND, 4'd5, 4'd1, 16'd2));
		prog.push_back(encode(`OP_OR, 4'd6, 4'd1, 16'd2));
		prog.push_back(encode(`OP_EOR, 4'd7, 4'd1, 16'd2));
		prog.push_back(encode(`OP_ADDI, 4'd0, 4'd1, 16'h0005));	// r0 discards the write
		for (int r = 3; r <= 8; r++) begin
			prog.push_back(encode(`OP_ST, (r == 8) ? 4'd0 : 4'(r), 4'd0,
				16'(32'h200 + 4 * (r - 3))));
			exp_addr.push_back(32'h200 + 4 * (r - 3));
		end
		exp_data.push_back(a + b);
		exp_data.push_back(a - b);
		exp_data.push_back(a & b);
		exp_data.push_back(a | b);
		exp_data.push_back(a ^ b);
		exp_data.push_back(32'h0);
		end_program();
		run_program();
	endtask

	task automatic branch_test();
		logic [31:0] va [6];
		logic [31:0] vb [6];
		logic        taken;
		va = '{32'h5, 32'h3, 32'h7, 32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFFF};
		vb = '{32'h5, 32'h7, 32'h3, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0001};
		for (int p = 0; p < 6; p++) begin
			for (int cc = 0; cc < 16; cc++) begin
				clear_program();
				pre_addr.push_back(32'h380);
				pre_data.push_back(va[3'(p)]);
				pre_addr.push_back(32'h384);
				pre_data.push_back(vb[3'(p)]);
				prog.push_back(encode(`OP_LD, 4'd1, 4'd0, 16'h0380));
				prog.push_back(encode(`OP_LD, 4'd2, 4'd0, 16'h0384));
				prog.push_back(encode(`OP_SUB, 4'd3, 4'd1, 16'd2));
				prog.push_back(encode(`OP_BCC, 4'(cc), 4'd0, 16'd2));	// taken skips two
				prog.push_back(encode(`OP_ST, 4'd1, 4'd0, 16'h0300));
				prog.push_back(encode(`OP_BCC, `CC_RA, 4'd0, 16'd1));
				prog.push_back(encode(`OP_ST, 4'd2, 4'd0, 16'h0304));
				taken = cond_model(4'(cc), va[3'(p)], vb[3'(p)]);
				exp_addr.push_back(taken ? 32'h304 : 32'h300);
				exp_data.push_back(taken ? vb[3'(p)] : va[3'(p)]);
				end_program();
				run_program();
			end
		end
	endtask

	task automatic load_test();
		clear_program();
		pre_addr.push_back(32'h2A0 + 32'h10);
		pre_data.push_back(32'h1234_FFFF);
		pre_addr.push_back(32'h2A0 - 32'h20);
		pre_data.push_back(32'hFFFF_FFFF);	// wraps to zero
		prog.push_back(encode(`OP_ADDI, 4'd5, 4'd0, 16'h02A0));
		prog.push_back(encode(`OP_LD, 4'd1, 4'd5, 16'h0010));
		prog.push_back(encode(`OP_LD, 4'd2, 4'd5, 16'hFFE0));
		prog.push_back(encode(`OP_ADDI, 4'd1, 4'd1, 16'h0001));
		prog.push_back(encode(`OP_ADDI, 4'd2, 4'd2, 16'h0001));
		prog.push_back(encode(`OP_ST, 4'd1, 4'd5, 16'h0010));
		prog.push_back(encode(`OP_ST, 4'd2, 4'd5, 16'hFFE0));
		for (int i = 0; i < 2; i++) begin
			exp_addr.push_back(pre_addr[i]);
			exp_data.push_back(pre_data[i] + 32'd1);
		end
		end_program();
		run_program();
	endtask

	task automatic program_suite();
		alu_test();
		branch_test();
		load_test();
	endtask

	// stores of the random ack pass against the zero delay pass
	task automatic compare_passes();
		checks++;
		if (all_st.size() != ref_st.size()) begin
			errors++;
			$display("store logs differ in length: %0d with delays, %0d without",
				all_st.size(), ref_st.size());
		end else begin
			for (int i = 0; i < ref_st.size(); i++) begin
				if (all_st[i] != ref_st[i]) begin
					errors++;
					$display("ERR adr_o,dat_o log %0d exp %h got %h", i, ref_st[i], all_st[i]);
				end
			end
		end
	endtask

	initial begin
		rst_i = 1'b1;
		rand_ack = 1'b0;
		errors = 0;
		checks = 0;
		fetch_test();
		all_st.delete();
		program_suite();
		ref_st = all_st;
		all_st.delete();
		rand_ack = 1'b1;
		program_suite();
		compare_passes();
		$display("checks %0d, errors %0d, bus assertion failures %0d", checks, errors,
			UUT.u_control.u_bus_props.violations);
		if (errors == 0 && UUT.u_control.u_bus_props.violations == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
cpu_pkg.sv
cpu_regfile.sv
cpu_alu.sv
cpu_branch_eval.sv
cpu_control.sv
cpu_top.sv
tb_cpu_properties.sv
tb_cpu.sv

//--- Makefile
TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

# the run is a failure if the log holds the fail message or lacks the pass message
sim:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -qF '*** FAILED ***' sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
